// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - verilog/fetch_pkg.sv
  - verilog/axi_lite_read_if.sv
  - verilog/icache.sv
  - verilog/fetch_unit.sv
  - verilog/fetch_top.sv
  - target: simulation
    files:
      - sim/tb_axi_mem.sv
      - sim/tb_fetch_top.sv

// ==== all.f ====
verilog/fetch_pkg.sv
verilog/axi_lite_read_if.sv
verilog/icache.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
sim/tb_axi_mem.sv
sim/tb_fetch_top.sv

// ==== sim/tb_axi_mem.sv ====
`timescale 1ns/1ns

// AXI4-Lite read subordinate serving a generated program
module tb_axi_mem
  import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       gen,
  input  addr_t      ar_addr,
  input  logic       ar_valid,
  output logic       ar_ready,
  output inst_t      r_data,
  output logic [1:0] r_resp,
  output logic       r_valid,
  input  logic       r_ready
);

  localparam addr_t jal_pc = 32'h8000_0040;
  localparam addr_t fwd_branch_pc = 32'h8000_0110;
  localparam addr_t back_branch_pc = 32'h8000_0120;

  integer seed = 32'hb0d5_56d0;
  logic phase;
  logic [1:0] delay;
  addr_t addr_q;

  // jal x0, imm
  function automatic inst_t encode_jal(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
  endfunction

  // bne x1, x2, imm
  function automatic inst_t encode_branch(input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b001, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // program image, addi everywhere except three control transfers
  function automatic inst_t program_word(input addr_t pc, input logic g);
    if (pc == jal_pc) begin
      return encode_jal(21'd192);
    end else if (pc == fwd_branch_pc) begin
      return encode_branch(13'd16);
    end else if (pc == back_branch_pc) begin
      return encode_branch(-13'sd32);
    end else begin
      return {g, pc[12:2], 5'd1, 3'b000, 5'd1, 7'b0010011};
    end
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      ar_ready <= 1'b0;
      r_valid <= 1'b0;
      r_data <= '0;
      r_resp <= 2'b00;
      phase <= 1'b0;
      delay <= {$random(seed)} % 4;
    end else if (!phase) begin
      if (ar_valid && ar_ready) begin
        ar_ready <= 1'b0;
        addr_q <= ar_addr;
        delay <= {$random(seed)} % 4;
        phase <= 1'b1;
      end else if (ar_valid) begin
        if (delay == 0) ar_ready <= 1'b1;
        else delay <= delay - 1;
      end
    end else begin
      if (r_valid && r_ready) begin
        r_valid <= 1'b0;
        delay <= {$random(seed)} % 4;
        phase <= 1'b0;
      end else if (!r_valid) begin
        if (delay == 0) begin
          r_valid <= 1'b1;
          r_data <= program_word(addr_q, gen);
        end else begin
          delay <= delay - 1;
        end
      end
    end
  end

endmodule

// ==== sim/tb_fetch_top.sv ====
`timescale 1ns/1ns

module tb_fetch_top
  import fetch_pkg::*;
();

  localparam addr_t loop_pc = 32'h8000_0100;
  localparam addr_t back_branch_pc = 32'h8000_0120;
  localparam int limit = 3000;

  logic clock, reset, gen, jump_flush, cs_flush, fencei, out_ready, out_valid;
  addr_t jump_dnpc, cs_dnpc, out_pc, ar_addr;
  inst_t out_inst, r_data, word, held_inst;
  logic ar_valid, ar_ready, r_valid, r_ready, hold_pending;
  logic [1:0] r_resp;
  // one bit per loop word read since the last fence.i
  logic [8:0] loop_reads;
  addr_t expected_pc, held_pc;
  integer seed = 32'hb0d5_56d0;
  int value_errors = 0, hold_errors = 0, cache_errors = 0;
  int accept_count = 0, ar_count = 0, ar_first = 0, branch_passes = 0, pass_mark;

  fetch_top fetch_top_inst (
    .clock(clock), .reset(reset), .jump_flush(jump_flush), .jump_dnpc(jump_dnpc),
    .cs_flush(cs_flush), .cs_dnpc(cs_dnpc), .fencei(fencei), .out_ready(out_ready),
    .out_valid(out_valid), .out_pc(out_pc), .out_inst(out_inst), .ar_addr(ar_addr),
    .ar_valid(ar_valid), .ar_ready(ar_ready), .r_data(r_data), .r_resp(r_resp),
    .r_valid(r_valid), .r_ready(r_ready)
  );

  tb_axi_mem mem_model (
    .clock(clock), .reset(reset), .gen(gen), .ar_addr(ar_addr), .ar_valid(ar_valid),
    .ar_ready(ar_ready), .r_data(r_data), .r_resp(r_resp), .r_valid(r_valid),
    .r_ready(r_ready)
  );

  // static prediction from the instruction encoding
  function automatic addr_t expected_next_pc(input addr_t pc, input inst_t inst);
    if (inst[6:0] == 7'b1100011 && inst[31])
      return pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    else if (inst[6:0] == 7'b1101111)
      return pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    else
      return pc + 32'd4;
  endfunction

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // random back-pressure, mostly ready
  always @(posedge clock) out_ready <= ({$random(seed)} % 4) != 0;

  always @(posedge clock) begin
    if (reset) begin
      expected_pc = reset_pc;
      hold_pending = 1'b0;
      loop_reads = '0;
    end else begin
      if (fencei) loop_reads = '0;
      if (ar_valid && ar_ready) begin
        ar_count++;
        if (ar_addr >= loop_pc && ar_addr <= back_branch_pc) begin
          loop_reads[(ar_addr - loop_pc) >> 2] = 1'b1;
        end
      end
      if (hold_pending && out_valid) begin
        assert (out_pc == held_pc && out_inst == held_inst) else begin
          hold_errors++;
          $display("error at %0t: held output %h/%h changed", $time, held_pc, held_inst);
        end
      end
      hold_pending = out_valid && !out_ready;
      held_pc = out_pc;
      held_inst = out_inst;
      if (cs_flush) begin
        expected_pc = cs_dnpc;
      end else if (jump_flush) begin
        expected_pc = jump_dnpc;
      end else if (out_valid && out_ready) begin
        word = mem_model.program_word(out_pc, gen);
        assert (out_pc == expected_pc) else begin
          value_errors++;
          $display("error at %0t: out_pc %h expected %h", $time, out_pc, expected_pc);
        end
        assert (out_inst == word) else begin
          value_errors++;
          $display("error at %0t: out_inst %h expected %h", $time, out_inst, word);
        end
        expected_pc = expected_next_pc(out_pc, word);
        accept_count++;
        if (out_pc == back_branch_pc) begin
          branch_passes++;
          if (branch_passes == 1) ar_first = ar_count;
          if (branch_passes == 2) begin
            assert (ar_count == ar_first) else begin
              cache_errors++;
              $display("error at %0t: second loop pass issued %0d reads", $time,
                       ar_count - ar_first);
            end
          end
        end
      end
    end
  end

  task automatic wait_accepts(input int n);
    int target;
    int cycles;
    target = accept_count + n;
    cycles = 0;
    while (accept_count < target && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (accept_count < target) begin
      $display("timeout while waiting for accepted instructions");
      $display("CHECKS FAILED");
      $finish;
    end
  endtask

  task automatic wait_branch_passes(input int n);
    int cycles;
    cycles = 0;
    while (branch_passes < n && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (branch_passes < n) begin
      $display("timeout while waiting for the loop branch");
      $display("CHECKS FAILED");
      $finish;
    end
  endtask

  task automatic wait_miss();
    int cycles;
    cycles = 0;
    while (!ar_valid && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!ar_valid) begin
      $display("timeout while waiting for a cache miss");
      $display("CHECKS FAILED");
      $finish;
    end
  endtask

  task automatic redirect(input logic jump, input addr_t jump_to, input logic cs,
                          input addr_t cs_to, input logic fence);
    @(posedge clock);
    jump_flush <= jump;
    jump_dnpc <= jump_to;
    cs_flush <= cs;
    cs_dnpc <= cs_to;
    fencei <= fence;
    if (fence) gen <= ~gen;
    @(posedge clock);
    jump_flush <= 1'b0;
    cs_flush <= 1'b0;
    fencei <= 1'b0;
  endtask

  initial begin
    reset = 1'b1;
    gen = 1'b0;
    jump_flush = 1'b0;
    jump_dnpc = '0;
    cs_flush = 1'b0;
    cs_dnpc = '0;
    fencei = 1'b0;
    out_ready = 1'b0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    assert (!ar_valid && !r_ready && !out_valid) else begin
      value_errors++;
      $display("error at %0t: ar_valid %b r_ready %b out_valid %b after reset", $time,
               ar_valid, r_ready, out_valid);
    end

    // straight line, jal into the loop, two passes
    wait_branch_passes(2);

    // new program generation after fence.i while the loop is still cached
    pass_mark = branch_passes;
    redirect(1'b1, loop_pc, 1'b0, '0, 1'b1);
    wait_branch_passes(pass_mark + 1);
    assert (loop_reads == '1) else begin
      cache_errors++;
      $display("error at %0t: loop words read after fence.i %b", $time, loop_reads);
    end
    wait_accepts(10);

    redirect(1'b1, 32'h8000_0020, 1'b0, '0, 1'b0);
    wait_accepts(5);
    redirect(1'b1, 32'h8000_0200, 1'b1, 32'h8000_0008, 1'b0);
    wait_accepts(5);

    // redirect while a fill is outstanding
    redirect(1'b1, 32'h8000_0080, 1'b0, '0, 1'b0);
    @(negedge clock);
    wait_miss();
    redirect(1'b1, 32'h8000_0300, 1'b0, '0, 1'b0);
    wait_accepts(6);

    $display("errors: value %0d, hold %0d, cache %0d", value_errors, hold_errors,
             cache_errors);
    if (value_errors + hold_errors + cache_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/axi_lite_read_if.sv ====
`timescale 1ns/1ns

// AXI4-Lite read address and read data channels only
interface axi_lite_read_if
  import fetch_pkg::*;
();

  addr_t araddr;
  logic arvalid;
  logic arready;
  inst_t rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;

  modport manager (
    output araddr, arvalid, rready,
    input  arready, rdata, rresp, rvalid
  );

  modport subordinate (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );

endinterface

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

  // address and instruction words
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // first fetch after reset
  localparam addr_t reset_pc = 32'h8000_0000;

  // direct-mapped geometry, one 4-byte word per line
  localparam int cache_lines = 16;
  localparam int index_bits = $clog2(cache_lines);
  localparam int tag_bits = 32 - index_bits - 2;

  typedef logic [index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0] tag_t;

  // major opcodes, inst[6:2]
  localparam logic [4:0] opcode_branch = 5'b11000;
  localparam logic [4:0] opcode_jal = 5'b11011;

  // miss fill sequence
  typedef enum logic [1:0] {
    state_idle,
    state_addr,
    state_data
  } cache_state_t;

endpackage

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top
  import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  input  logic       jump_flush,
  input  addr_t      jump_dnpc,
  input  logic       cs_flush,
  input  addr_t      cs_dnpc,
  input  logic       fencei,

  input  logic       out_ready,
  output logic       out_valid,
  output addr_t      out_pc,
  output inst_t      out_inst,

  output addr_t      ar_addr,
  output logic       ar_valid,
  input  logic       ar_ready,
  input  inst_t      r_data,
  input  logic [1:0] r_resp,
  input  logic       r_valid,
  output logic       r_ready
);

  axi_lite_read_if mem_bus ();

  fetch_unit fetch_unit_inst (
    .clock      (clock),
    .reset      (reset),
    .mem        (mem_bus.manager),
    .jump_flush (jump_flush),
    .jump_dnpc  (jump_dnpc),
    .cs_flush   (cs_flush),
    .cs_dnpc    (cs_dnpc),
    .fencei     (fencei),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_pc     (out_pc),
    .out_inst   (out_inst)
  );

  // memory side of the bus to plain ports
  assign ar_addr = mem_bus.araddr;
  assign ar_valid = mem_bus.arvalid;
  assign r_ready = mem_bus.rready;
  assign mem_bus.arready = ar_ready;
  assign mem_bus.rdata = r_data;
  assign mem_bus.rresp = r_resp;
  assign mem_bus.rvalid = r_valid;

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,

  axi_lite_read_if.manager mem,

  input  logic  jump_flush,
  input  addr_t jump_dnpc,
  input  logic  cs_flush,
  input  addr_t cs_dnpc,
  input  logic  fencei,

  input  logic  out_ready,
  output logic  out_valid,
  output addr_t out_pc,
  output inst_t out_inst
);

  addr_t fetch_pc;
  logic hit;
  inst_t cache_inst;

  addr_t imm_b;
  addr_t imm_j;
  addr_t pc_incr;
  addr_t pred_pc;

  logic flush;
  addr_t flush_pc;
  logic flush_pend;
  logic flush_any;
  addr_t redirect_pc;

  logic out_valid_q;
  logic out_free;
  logic take;

  icache icache_inst (
    .clock  (clock),
    .reset  (reset),
    .fencei (fencei),
    .addr   (fetch_pc),
    .hit    (hit),
    .inst   (cache_inst),
    .mem    (mem)
  );

  // static prediction, backward branches and jal taken
  assign imm_b = {{20{cache_inst[31]}}, cache_inst[7], cache_inst[30:25],
                  cache_inst[11:8], 1'b0};
  assign imm_j = {{12{cache_inst[31]}}, cache_inst[19:12], cache_inst[20],
                  cache_inst[30:21], 1'b0};

  always_comb begin
    case (cache_inst[6:2])
      opcode_branch: pc_incr = cache_inst[31] ? imm_b : 32'd4;
      opcode_jal: pc_incr = imm_j;
      default: pc_incr = 32'd4;
    endcase
  end

  assign pred_pc = fetch_pc + pc_incr;

  // cs_flush has priority over jump_flush
  assign flush = jump_flush | cs_flush;
  assign flush_pc = cs_flush ? cs_dnpc : jump_dnpc;
  assign flush_any = flush | flush_pend;

  // stage accepts a new word when empty or being drained
  assign out_free = !out_valid_q || out_ready;
  assign take = hit && !flush_any && out_free;

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc <= reset_pc;
      flush_pend <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (flush) begin
        if (hit) fetch_pc <= flush_pc;
      end else if (flush_pend) begin
        if (hit) fetch_pc <= redirect_pc;
      end else if (take) begin
        fetch_pc <= pred_pc;
      end

      // remembered until the outstanding fill returns
      flush_pend <= flush_any && !hit;

      if (flush) begin
        out_valid_q <= 1'b0;
      end else if (take) begin
        out_valid_q <= 1'b1;
      end else if (out_ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // newest redirect target wins while waiting
  always_ff @(posedge clock) begin
    if (flush && !hit) begin
      redirect_pc <= flush_pc;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      out_pc <= fetch_pc;
      out_inst <= cache_inst;
    end
  end

  // a flush kills the held word in the same cycle
  assign out_valid = out_valid_q && !flush;

  out_hold: assert property (
    @(posedge clock) disable iff (reset)
    out_valid && !out_ready && !flush |=> $stable(out_pc) && $stable(out_inst)
  ) else $error("fetch_unit: output changed under back-pressure at %0t", $time);

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ns

module icache
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  fencei,
  input  addr_t addr,
  output logic  hit,
  output inst_t inst,
  axi_lite_read_if.manager mem
);

  // line storage
  logic [cache_lines-1:0] valid_bits;
  tag_t tag_array [cache_lines];
  inst_t data_array [cache_lines];

  index_t lookup_index;
  tag_t lookup_tag;

  cache_state_t state;
  cache_state_t state_next;

  // address of the word being filled
  addr_t fill_addr;
  index_t fill_index;
  tag_t fill_tag;
  logic fill_killed;
  logic fill_done;

  assign lookup_index = addr[index_bits+1:2];
  assign lookup_tag = addr[31:index_bits+2];

  // lookup is purely combinational
  assign hit = valid_bits[lookup_index] && (tag_array[lookup_index] == lookup_tag);
  assign inst = data_array[lookup_index];

  assign fill_index = fill_addr[index_bits+1:2];
  assign fill_tag = fill_addr[31:index_bits+2];
  assign fill_done = (state == state_data) && mem.rvalid;

  always_comb begin
    state_next = state;
    case (state)
      state_idle: if (!hit) state_next = state_addr;
      state_addr: if (mem.arready) state_next = state_data;
      state_data: if (mem.rvalid) state_next = state_idle;
      default: state_next = state_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      state <= state_next;
    end
  end

  // latch the missing address, held until the fill ends
  always_ff @(posedge clock) begin
    if (state == state_idle && !hit) begin
      fill_addr <= {addr[31:2], 2'b00};
    end
  end

  // fence.i seen mid-fill, the returning word is stale
  always_ff @(posedge clock) begin
    if (reset || state == state_idle) begin
      fill_killed <= 1'b0;
    end else if (fencei) begin
      fill_killed <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || fencei) begin
      valid_bits <= '0;
    end else if (fill_done && !fill_killed) begin
      valid_bits[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_done) begin
      tag_array[fill_index] <= fill_tag;
      data_array[fill_index] <= mem.rdata;
    end
  end

  assign mem.araddr = fill_addr;
  assign mem.arvalid = (state == state_addr);
  assign mem.rready = (state == state_data);

  // request must not move or drop before it is accepted
  ar_hold: assert property (
    @(posedge clock) disable iff (reset)
    mem.arvalid && !mem.arready |=> mem.arvalid && $stable(mem.araddr)
  ) else $error("icache: AR request changed before arready at %0t", $time);

  // only OKAY is expected from instruction memory
  r_okay: assert property (
    @(posedge clock) disable iff (reset)
    mem.rvalid && mem.rready |-> mem.rresp == 2'b00
  ) else $error("icache: rresp %b for %h at %0t", mem.rresp, fill_addr, $time);

endmodule
